// File: Bender.yml
package:
  name: seq_array_multiplier

sources:
  - files:
      - mulPkg.sv
      - mulCtrlPkg.sv
      - partialRowStage.sv
      - stepCounter.sv
      - mulControl.sv
      - productAccumulator.sv
      - seqArrayMultiplier.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbMultiplier.sv

// File: compile.f
+incdir+.
mulPkg.sv
mulCtrlPkg.sv
partialRowStage.sv
stepCounter.sv
mulControl.sv
productAccumulator.sv
seqArrayMultiplier.sv
tbMultiplier.sv

// File: mulControl.sv
`timescale 1ns/1ps
`default_nettype none

module mulControl (
  input  logic clk,
  input  logic rstN,
  input  logic inValid,
  output logic inReady,
  output logic outValid,
  input  logic outReady,
  input  logic lastStep,
  output logic load,
  output logic step
);

  import mulCtrlPkg::*;

  mulStateT state;
  mulStateT nextState;

  logic inFire;
  logic outFire;

  // Channel status follows the state alone
  assign inReady  = (state == Idle);
  assign outValid = (state == Hold);

  assign inFire  = inValid && inReady;
  assign outFire = outValid && outReady;

  // Operands are captured on the accepting edge
  assign load = inFire;
  assign step = (state == Busy);

  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (inFire) begin
          nextState = Busy;
        end
      end
      Busy: begin
        if (step && lastStep) begin
          nextState = Hold;
        end
      end
      Hold: begin
        // Result held until the consumer takes it
        if (outFire) begin
          nextState = Idle;
        end
      end
      default: begin
        nextState = Idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

endmodule

`default_nettype wire

// File: mulCtrlPkg.sv
`default_nettype none

package mulCtrlPkg;

  // Controller states
  typedef enum logic [1:0] {
    Idle,
    Busy,
    Hold
  } mulStateT;

  // Wide enough for 24 steps at one row per cycle
  localparam int StepCountWidth = 5;

  typedef logic [StepCountWidth-1:0] stepCountT;

endpackage

`default_nettype wire

// File: mulPkg.sv
`default_nettype none

package mulPkg;

  // Operand and product widths
  localparam int OperandWidth = 24;
  localparam int ProductWidth = 2 * OperandWidth;

  // Rows evaluated per clock unless the top level picks another value
  // OperandWidth must be a multiple of it
  localparam int DefaultRowsPerCycle = 4;

  // Unsigned multiplicand or multiplier
  typedef logic [OperandWidth-1:0] operandT;

  // Full unsigned product
  typedef logic [ProductWidth-1:0] productT;

endpackage

`default_nettype wire

// File: partialRowStage.sv
`timescale 1ns/1ps
`default_nettype none

module partialRowStage #(
  parameter int RowsPerCycle = mulPkg::DefaultRowsPerCycle
) (
  input  mulPkg::operandT          multiplicand,
  input  mulPkg::operandT          sumIn,
  input  logic [RowsPerCycle-1:0]  multiplierBits,
  output mulPkg::operandT          sumOut,
  output logic [RowsPerCycle-1:0]  retiredBits
);

  import mulPkg::*;

  // Running sum entering each row, the last entry leaves the stage
  wire [OperandWidth-1:0] rowSum [RowsPerCycle+1];

  // Lowest sum bit of every row
  wire [RowsPerCycle-1:0] retired;

  assign rowSum[0] = sumIn;

  for (genvar row = 0; row < RowsPerCycle; row++) begin : gRow
    // Partial product of this row
    wire [OperandWidth-1:0] partial;
    // Full adder sums before the one-bit shift
    wire [OperandWidth-1:0] rowBits;
    // Ripple carry, bit 0 is the row's carry-in
    wire [OperandWidth:0]   carry;

    assign partial  = multiplicand & {OperandWidth{multiplierBits[row]}};
    assign carry[0] = 1'b0;

    for (genvar bitIdx = 0; bitIdx < OperandWidth; bitIdx++) begin : gBit
      wire halfSum;

      assign halfSum         = rowSum[row][bitIdx] ^ partial[bitIdx];
      assign rowBits[bitIdx] = halfSum ^ carry[bitIdx];
      assign carry[bitIdx+1] = (rowSum[row][bitIdx] & partial[bitIdx]) |
                               (carry[bitIdx] & halfSum);
    end

    // Bit 0 is final, the carry-out becomes the new top of the sum
    assign retired[row]  = rowBits[0];
    assign rowSum[row+1] = {carry[OperandWidth], rowBits[OperandWidth-1:1]};
  end

  assign sumOut      = rowSum[RowsPerCycle];
  assign retiredBits = retired;

endmodule

`default_nettype wire

// File: productAccumulator.sv
`timescale 1ns/1ps
`default_nettype none

module productAccumulator #(
  parameter int RowsPerCycle = mulPkg::DefaultRowsPerCycle
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            load,
  input  logic            step,
  input  mulPkg::operandT operandA,
  input  mulPkg::operandT operandB,
  output mulPkg::productT product
);

  import mulPkg::*;

  operandT multiplicand;
  operandT multiplier;

  // Upper half of the product as it builds up
  operandT runSum;

  // Retired product bits, filled from the top down
  operandT productLow;

  operandT                 nextSum;
  logic [RowsPerCycle-1:0] retiredBits;

  // Retired bits joined above the low register, shifted by one step
  logic [OperandWidth+RowsPerCycle-1:0] lowShift;

  partialRowStage #(
    .RowsPerCycle(RowsPerCycle)
  ) uRowStage (
    .multiplicand  (multiplicand),
    .sumIn         (runSum),
    .multiplierBits(multiplier[RowsPerCycle-1:0]),
    .sumOut        (nextSum),
    .retiredBits   (retiredBits)
  );

  assign lowShift = {retiredBits, productLow};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      multiplicand <= '0;
      multiplier   <= '0;
      runSum       <= '0;
      productLow   <= '0;
    end else if (load) begin
      multiplicand <= operandA;
      multiplier   <= operandB;
      runSum       <= '0;
      productLow   <= '0;
    end else if (step) begin
      runSum     <= nextSum;
      // Next group of multiplier bits moves to the bottom
      multiplier <= multiplier >> RowsPerCycle;
      productLow <= lowShift[OperandWidth+RowsPerCycle-1:RowsPerCycle];
    end
  end

  assign product = {runSum, productLow};

endmodule

`default_nettype wire

// File: seqArrayMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module seqArrayMultiplier #(
  parameter int RowsPerCycle = mulPkg::DefaultRowsPerCycle
) (
  input  logic            clk,
  input  logic            rstN,
  // Request channel
  input  logic            inValid,
  output logic            inReady,
  input  mulPkg::operandT operandA,
  input  mulPkg::operandT operandB,
  // Result channel
  output logic            outValid,
  input  logic            outReady,
  output mulPkg::productT product
);

  logic load;
  logic step;
  logic lastStep;

  mulControl uControl (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .inReady (inReady),
    .outValid(outValid),
    .outReady(outReady),
    .lastStep(lastStep),
    .load    (load),
    .step    (step)
  );

  // Tracks the steps of one operation
  stepCounter #(
    .RowsPerCycle(RowsPerCycle)
  ) uStepCounter (
    .clk     (clk),
    .rstN    (rstN),
    .load    (load),
    .step    (step),
    .lastStep(lastStep)
  );

  // Shift-and-add data path
  productAccumulator #(
    .RowsPerCycle(RowsPerCycle)
  ) uAccumulator (
    .clk     (clk),
    .rstN    (rstN),
    .load    (load),
    .step    (step),
    .operandA(operandA),
    .operandB(operandB),
    .product (product)
  );

endmodule

`default_nettype wire

// File: stepCounter.sv
`timescale 1ns/1ps
`default_nettype none

module stepCounter #(
  parameter int RowsPerCycle = mulPkg::DefaultRowsPerCycle
) (
  input  logic clk,
  input  logic rstN,
  input  logic load,
  input  logic step,
  output logic lastStep
);

  import mulPkg::*;
  import mulCtrlPkg::*;

  localparam int        NumSteps  = OperandWidth / RowsPerCycle;
  localparam stepCountT LastCount = stepCountT'(NumSteps - 1);

  // Steps completed in the current operation
  stepCountT count;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      count <= '0;
    end else if (load) begin
      count <= '0;
    end else if (step) begin
      count <= count + 1'b1;
    end
  end

  // High during the final step
  assign lastStep = (count == LastCount);

endmodule

`default_nettype wire

// File: tbTasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Channel status once reset is released
task automatic testResetState();
  int errorsBefore;
  errorsBefore = errorCount;
  @(negedge clk);
  checkNumber("resetState", "outValid", 0, outValid);
  checkNumber("resetState", "inReady", 1, inReady);
  @(posedge clk);
  finishTest("resetState", errorsBefore);
endtask

task automatic testCorners();
  int errorsBefore;
  int waited;
  int edges;
  errorsBefore = errorCount;
  runOperation("corners", 24'h000000, 24'hABCDEF, waited, edges);
  runOperation("corners", 24'h000001, 24'h5A5A5A, waited, edges);
  runOperation("corners", 24'hFFFFFF, 24'hFFFFFF, waited, edges);
  // Only the top bit of each operand
  runOperation("corners", 24'h800000, 24'h800000, waited, edges);
  finishTest("corners", errorsBefore);
endtask

task automatic testRandom();
  int      errorsBefore;
  int      waited;
  int      edges;
  int      pairIdx;
  operandT a;
  operandT b;
  errorsBefore = errorCount;
  for (pairIdx = 0; pairIdx < 20; pairIdx++) begin
    a = operandT'($random(seed));
    b = operandT'($random(seed));
    runOperation("random", a, b, waited, edges);
  end
  finishTest("random", errorsBefore);
endtask

// Rising edges from the input transfer to outValid
task automatic testLatency();
  int errorsBefore;
  int waited;
  int edges;
  errorsBefore = errorCount;
  runOperation("latency", 24'h3C3C3C, 24'h00A5A5, waited, edges);
  checkNumber("latency", "edges to outValid", NumSteps, edges);
  finishTest("latency", errorsBefore);
endtask

task automatic testBackPressure();
  int      errorsBefore;
  int      waited;
  int      edges;
  int      cycle;
  bit      ok;
  productT held;
  errorsBefore = errorCount;
  outReady <= 1'b0;
  sendRequest("backPressure", 24'h123456, 24'h654321, waited, ok);
  if (ok) begin
    waitResult("backPressure", edges, ok);
  end
  if (ok) begin
    held = product;
    checkProduct("backPressure", expectedProduct(24'h123456, 24'h654321), held);
    for (cycle = 0; cycle < 10; cycle++) begin
      @(posedge clk);
      @(negedge clk);
      checkNumber("backPressure", "outValid while held", 1, outValid);
      checkNumber("backPressure", "inReady while held", 0, inReady);
      checkProduct("backPressure", held, product);
    end
  end
  @(posedge clk);
  outReady <= 1'b1;
  // Output transfer edge
  @(posedge clk);
  runOperation("backPressure", 24'h0F0F0F, 24'h00FFFF, waited, edges);
  finishTest("backPressure", errorsBefore);
endtask

// Each request follows the previous output transfer directly
task automatic testBackToBack();
  int      errorsBefore;
  int      waited;
  int      edges;
  int      opIdx;
  operandT aList [3];
  operandT bList [3];
  errorsBefore = errorCount;
  aList[0] = 24'hC0FFEE;
  bList[0] = 24'h000123;
  aList[1] = 24'h7FFFFF;
  bList[1] = 24'h800001;
  aList[2] = 24'h000002;
  bList[2] = 24'hFEDCBA;
  for (opIdx = 0; opIdx < 3; opIdx++) begin
    runOperation("backToBack", aList[opIdx], bList[opIdx], waited, edges);
    checkNumber("backToBack", "cycles waiting for inReady", 0, waited);
  end
  finishTest("backToBack", errorsBefore);
endtask

`endif

// File: tbMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module tbMultiplier;

  import mulPkg::*;

  localparam int ClockPeriod = 40;
  localparam int ResetCycles = 16;
  localparam int NumSteps    = OperandWidth / DefaultRowsPerCycle;
  // Longest handshake wait, in cycles
  localparam int WaitLimit   = 200;

  logic    clk;
  logic    rstN;
  logic    inValid;
  logic    inReady;
  operandT operandA;
  operandT operandB;
  logic    outValid;
  logic    outReady;
  productT product;

  int errorCount;
  int checkCount;
  int testCount;
  int seed;

  seqArrayMultiplier #(
    .RowsPerCycle(DefaultRowsPerCycle)
  ) u_dut (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .inReady (inReady),
    .operandA(operandA),
    .operandB(operandB),
    .outValid(outValid),
    .outReady(outReady),
    .product (product)
  );

  initial begin
    clk = 1'b0;
    forever #(ClockPeriod / 2) clk = ~clk;
  end

  // Plain unsigned product at full width
  function automatic productT expectedProduct(input operandT a, input operandT b);
    productT wideA;
    productT wideB;
    wideA = productT'(a);
    wideB = productT'(b);
    return wideA * wideB;
  endfunction

  function automatic void checkProduct(input string testName, input productT expected,
                                       input productT actual);
    checkCount++;
    if (actual !== expected) begin
      $display("mismatch %s product expected=%h actual=%h", testName, expected, actual);
      errorCount++;
    end
  endfunction

  // Four-state compare so that an unknown value never passes
  function automatic void checkNumber(input string testName, input string label,
                                      input logic [31:0] expected,
                                      input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      $display("mismatch %s %s expected=%0d actual=%0d", testName, label, expected, actual);
      errorCount++;
    end
  endfunction

  function automatic void reportFailure(input string testName, input string text);
    $display("%s: %s", testName, text);
    errorCount++;
  endfunction

  function automatic void finishTest(input string testName, input int errorsBefore);
    testCount++;
    $display("test %s finished with %0d errors", testName, errorCount - errorsBefore);
  endfunction

  // Called right after a rising edge, returns right after the accepting edge
  task automatic sendRequest(input string testName, input operandT a, input operandT b,
                             output int waited, output bit ok);
    inValid  <= 1'b1;
    operandA <= a;
    operandB <= b;
    waited = 0;
    @(negedge clk);
    while (!inReady && waited < WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    ok = inReady;
    if (!ok) begin
      reportFailure(testName, "inReady never rose, so the request was not accepted");
    end
    @(posedge clk);
    inValid <= 1'b0;
  endtask

  // Counts rising edges until outValid is seen, returns on the falling edge
  task automatic waitResult(input string testName, output int edges, output bit ok);
    edges = 0;
    ok = 1'b0;
    while (!ok && edges < WaitLimit) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      ok = outValid;
    end
    if (!ok) begin
      reportFailure(testName, "outValid never rose, so no result was delivered");
    end
  endtask

  // One full operation with outReady high
  task automatic runOperation(input string testName, input operandT a, input operandT b,
                              output int waited, output int edges);
    bit ok;
    edges = 0;
    sendRequest(testName, a, b, waited, ok);
    if (ok) begin
      waitResult(testName, edges, ok);
      if (ok) begin
        checkProduct(testName, expectedProduct(a, b), product);
      end
      // Output transfer edge
      @(posedge clk);
    end
  endtask

  `include "tbTasks.svh"

  initial begin
    seed       = 58;
    errorCount = 0;
    checkCount = 0;
    testCount  = 0;
    rstN       = 1'b0;
    inValid    = 1'b0;
    operandA   = '0;
    operandB   = '0;
    outReady   = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;

    testResetState();
    testCorners();
    testRandom();
    testLatency();
    testBackPressure();
    testBackToBack();

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
